// ==== source/aznable_pkg.sv ====
package aznable_pkg;

	// Bus and data widths
	typedef logic [15:0] addr_t;
	typedef logic [7:0] byte_t;
	typedef logic [15:0] timer_t;
	typedef logic [7:0] colour_t;

	// clk_24 cycles in one millisecond
	localparam int TICKS_PER_MS = 24000;
	localparam int PRESCALE_W = $clog2(TICKS_PER_MS);
	typedef logic [PRESCALE_W-1:0] prescale_t;

	// High address byte of each memory mapped input region
	localparam byte_t REGION_IN0       = 8'h80;
	localparam byte_t REGION_JOYSTICK  = 8'h81;
	localparam byte_t REGION_ANALOG_L  = 8'h82;
	localparam byte_t REGION_ANALOG_R  = 8'h83;
	localparam byte_t REGION_PADDLE    = 8'h84;
	localparam byte_t REGION_SPINNER   = 8'h85;
	localparam byte_t REGION_PS2_KEY   = 8'h86;
	localparam byte_t REGION_PS2_MOUSE = 8'h87;
	localparam byte_t REGION_TIMESTAMP = 8'h88;
	localparam byte_t REGION_TIMER     = 8'h89;

	// System control bytes
	localparam addr_t ADDR_PAUSE = 16'h8A30;
	localparam addr_t ADDR_MENU  = 16'h8A31;

	typedef struct packed {
		addr_t addr;
		byte_t data;
		logic  wr_n;
	} cpu_bus_t;

	typedef struct packed {
		logic hs;
		logic vs;
		logic hblank;
		logic vblank;
	} video_sync_t;

	// Host side inputs, one entry per device packed low to high
	typedef struct packed {
		logic [191:0] joystick;
		logic [95:0]  analog_l;
		logic [95:0]  analog_r;
		logic [47:0]  paddle;
		logic [95:0]  spinner;
		logic [10:0]  ps2_key;
		logic [47:0]  ps2_mouse;
		logic [32:0]  timestamp;
	} host_inputs_t;

	typedef struct packed {
		logic in0;
		logic joystick;
		logic analog_l;
		logic analog_r;
		logic paddle;
		logic spinner;
		logic ps2_key;
		logic ps2_mouse;
		logic timestamp;
		logic timer;
		logic timer_wr;
		logic pause_wr;
		logic menu_rd;
		logic menu_wr;
	} io_select_t;

	typedef struct packed {
		logic    active;
		colour_t r;
		colour_t g;
		colour_t b;
	} layer_pixel_t;

	typedef struct packed {
		logic  on;
		byte_t brightness;
	} star_pixel_t;

	typedef struct packed {
		colour_t r;
		colour_t g;
		colour_t b;
	} rgb_t;

endpackage

// ==== source/address_decoder.sv ====
module address_decoder (
	input  aznable_pkg::cpu_bus_t   bus,
	output aznable_pkg::io_select_t sel
);

	aznable_pkg::byte_t region;
	logic write;
	logic pause_hit;
	logic menu_hit;

	assign region = bus.addr[15:8];
	assign write = !bus.wr_n;
	assign pause_hit = bus.addr == aznable_pkg::ADDR_PAUSE;
	assign menu_hit = bus.addr == aznable_pkg::ADDR_MENU;

	always_comb
	begin
		// Input regions, one page each
		sel.in0       = region == aznable_pkg::REGION_IN0;
		sel.joystick  = region == aznable_pkg::REGION_JOYSTICK;
		sel.analog_l  = region == aznable_pkg::REGION_ANALOG_L;
		sel.analog_r  = region == aznable_pkg::REGION_ANALOG_R;
		sel.paddle    = region == aznable_pkg::REGION_PADDLE;
		sel.spinner   = region == aznable_pkg::REGION_SPINNER;
		sel.ps2_key   = region == aznable_pkg::REGION_PS2_KEY;
		sel.ps2_mouse = region == aznable_pkg::REGION_PS2_MOUSE;
		sel.timestamp = region == aznable_pkg::REGION_TIMESTAMP;
		sel.timer     = region == aznable_pkg::REGION_TIMER;

		// Any write into the timer page clears it
		sel.timer_wr = sel.timer && write;

		// Control bytes need the full address
		sel.pause_wr = pause_hit && write;
		sel.menu_rd  = menu_hit && !write;
		sel.menu_wr  = menu_hit && write;

		// Region pages and control bytes must never overlap
		assert ($onehot0({sel.in0, sel.joystick, sel.analog_l, sel.analog_r,
			sel.paddle, sel.spinner, sel.ps2_key, sel.ps2_mouse,
			sel.timestamp, sel.timer, sel.pause_wr, sel.menu_rd, sel.menu_wr}))
		else
			$error("address_decoder: overlapping selects at %h", bus.addr);
	end

endmodule

// ==== source/input_port_mux.sv ====
module input_port_mux (
	input  logic                      clk_24,
	input  logic                      arst_n,
	input  aznable_pkg::io_select_t   sel,
	input  aznable_pkg::addr_t        addr,
	input  aznable_pkg::host_inputs_t host,
	input  aznable_pkg::video_sync_t  sync,
	input  logic                      menu_req,
	input  aznable_pkg::timer_t       timer,
	output aznable_pkg::byte_t        cpu_din
);

	// Inputs padded to a power of two bytes so spare indices read as 0
	logic [255:0] joystick_pad;
	logic [127:0] analog_l_pad;
	logic [127:0] analog_r_pad;
	logic [63:0]  paddle_pad;
	logic [127:0] spinner_pad;
	logic [15:0]  ps2_key_pad;
	logic [63:0]  ps2_mouse_pad;
	logic [63:0]  timestamp_pad;
	aznable_pkg::byte_t status;

	assign joystick_pad  = {64'd0, host.joystick};
	assign analog_l_pad  = {32'd0, host.analog_l};
	assign analog_r_pad  = {32'd0, host.analog_r};
	assign paddle_pad    = {16'd0, host.paddle};
	assign spinner_pad   = {32'd0, host.spinner};
	assign ps2_key_pad   = {5'd0, host.ps2_key};
	assign ps2_mouse_pad = {16'd0, host.ps2_mouse};
	assign timestamp_pad = {31'd0, host.timestamp};

	// Sync and blank levels on top, menu request near the bottom
	assign status = {sync.hs, sync.vs, sync.hblank, sync.vblank, 2'b10, menu_req, 1'b0};

	always_comb
	begin
		if (sel.in0)
			cpu_din = status;
		else if (sel.joystick)
			cpu_din = joystick_pad[{addr[4:0], 3'b000} +: 8];
		else if (sel.analog_l)
			cpu_din = analog_l_pad[{addr[3:0], 3'b000} +: 8];
		else if (sel.analog_r)
			cpu_din = analog_r_pad[{addr[3:0], 3'b000} +: 8];
		else if (sel.paddle)
			cpu_din = paddle_pad[{addr[2:0], 3'b000} +: 8];
		else if (sel.spinner)
			cpu_din = spinner_pad[{addr[3:0], 3'b000} +: 8];
		else if (sel.ps2_key)
			cpu_din = ps2_key_pad[{addr[0], 3'b000} +: 8];
		else if (sel.ps2_mouse)
			cpu_din = ps2_mouse_pad[{addr[2:0], 3'b000} +: 8];
		else if (sel.timestamp)
			cpu_din = timestamp_pad[{addr[2:0], 3'b000} +: 8];
		else if (sel.timer)
			cpu_din = timer[{addr[0], 3'b000} +: 8];
		else if (sel.menu_rd)
			cpu_din = {8{menu_req}};
		else
			cpu_din = '0;
	end

	// The key code is only two bytes deep
	ps2_key_in_range: assert property (@(posedge clk_24) disable iff (!arst_n)
		sel.ps2_key |-> addr[7:1] == 7'd0);

endmodule

// ==== source/system_control.sv ====
module system_control (
	input  logic                    clk_24,
	input  logic                    arst_n,
	input  aznable_pkg::io_select_t sel,
	input  logic                    pause,
	input  logic                    menu,
	output logic                    pause_system,
	output logic                    menu_req,
	output aznable_pkg::timer_t     timer
);

	aznable_pkg::prescale_t prescale;
	logic pause_latch;
	logic menu_latch;
	logic ms_tick;

	assign ms_tick = prescale == aznable_pkg::prescale_t'(aznable_pkg::TICKS_PER_MS - 1);

	// Millisecond counter, cleared by any CPU write to the timer page
	always_ff @(posedge clk_24 or negedge arst_n)
	begin
		if (!arst_n)
		begin
			prescale <= '0;
			timer <= '0;
		end
		else if (sel.timer_wr)
		begin
			prescale <= '0;
			timer <= '0;
		end
		else if (ms_tick)
		begin
			prescale <= '0;
			timer <= timer + 1'b1;
		end
		else
			prescale <= prescale + 1'b1;
	end

	// CPU requests a pause, host pause releases the request
	always_ff @(posedge clk_24 or negedge arst_n)
	begin
		if (!arst_n)
			pause_latch <= 1'b0;
		else if (pause)
			pause_latch <= 1'b0;
		else if (sel.pause_wr)
			pause_latch <= 1'b1;
	end

	// Host opens the menu, CPU acknowledges with a write
	always_ff @(posedge clk_24 or negedge arst_n)
	begin
		if (!arst_n)
			menu_latch <= 1'b0;
		else if (sel.menu_wr)
			menu_latch <= 1'b0;
		else if (menu)
			menu_latch <= 1'b1;
	end

	// Host pause takes effect without waiting for an edge
	assign pause_system = pause || pause_latch;
	assign menu_req = menu_latch;

	prescale_in_range: assert property (@(posedge clk_24) disable iff (!arst_n)
		prescale < aznable_pkg::TICKS_PER_MS);

endmodule

// ==== source/layer_mixer.sv ====
module layer_mixer (
	input  aznable_pkg::layer_pixel_t charmap,
	input  aznable_pkg::layer_pixel_t sprite,
	input  aznable_pkg::layer_pixel_t tilemap,
	input  aznable_pkg::star_pixel_t  stars [3],
	output aznable_pkg::rgb_t         pixel
);

	aznable_pkg::colour_t star_grey;
	logic star_on;

	// Farther star layers are dimmer, so fewer brightness bits pass
	always_comb
	begin
		if (stars[0].on)
			star_grey = stars[0].brightness;
		else if (stars[1].on)
			star_grey = {1'b0, stars[1].brightness[6:0]};
		else if (stars[2].on)
			star_grey = {2'b00, stars[2].brightness[5:0]};
		else
			star_grey = '0;
	end

	assign star_on = stars[0].on || stars[1].on || stars[2].on;

	// Text over sprites over tiles over stars
	always_comb
	begin
		if (charmap.active)
			pixel = '{r: charmap.r, g: charmap.g, b: charmap.b};
		else if (sprite.active)
			pixel = '{r: sprite.r, g: sprite.g, b: sprite.b};
		else if (tilemap.active)
			pixel = '{r: tilemap.r, g: tilemap.g, b: tilemap.b};
		else if (star_on)
			pixel = '{r: star_grey, g: star_grey, b: star_grey};
		else
			pixel = '0;
	end

endmodule

// ==== source/system_io.sv ====
module system_io (
	input  logic                      clk_24,
	input  logic                      arst_n,
	input  aznable_pkg::cpu_bus_t     bus,
	output aznable_pkg::byte_t        cpu_din,
	input  aznable_pkg::host_inputs_t host,
	input  aznable_pkg::video_sync_t  sync,
	input  logic                      pause,
	input  logic                      menu,
	input  aznable_pkg::layer_pixel_t charmap,
	input  aznable_pkg::layer_pixel_t sprite,
	input  aznable_pkg::layer_pixel_t tilemap,
	input  aznable_pkg::star_pixel_t  stars [3],
	output logic                      pause_system,
	output aznable_pkg::rgb_t         pixel
);

	aznable_pkg::io_select_t sel;
	aznable_pkg::timer_t timer;
	logic menu_req;

	address_decoder i_address_decoder (
		.bus (bus),
		.sel (sel)
	);

	// Read data path back to the CPU
	input_port_mux i_input_port_mux (
		.clk_24   (clk_24),
		.arst_n   (arst_n),
		.sel      (sel),
		.addr     (bus.addr),
		.host     (host),
		.sync     (sync),
		.menu_req (menu_req),
		.timer    (timer),
		.cpu_din  (cpu_din)
	);

	system_control i_system_control (
		.clk_24       (clk_24),
		.arst_n       (arst_n),
		.sel          (sel),
		.pause        (pause),
		.menu         (menu),
		.pause_system (pause_system),
		.menu_req     (menu_req),
		.timer        (timer)
	);

	layer_mixer i_layer_mixer (
		.charmap (charmap),
		.sprite  (sprite),
		.tilemap (tilemap),
		.stars   (stars),
		.pixel   (pixel)
	);

endmodule

// ==== sim/tb_system_io.sv ====
module tb_system_io;

	// One CPU bus cycle with its host inputs and the expected responses
	typedef struct packed {
		aznable_pkg::addr_t addr;
		logic               wr;
		aznable_pkg::byte_t data;
		logic               pause;
		logic               menu;
		int unsigned        wait_cycles;
		logic               check_din;
		aznable_pkg::byte_t exp_din;
		logic               exp_pause;
	} bus_step_t;

	logic                      clk_24 = 1'b0;
	logic                      arst_n;
	aznable_pkg::cpu_bus_t     bus;
	aznable_pkg::byte_t        cpu_din;
	aznable_pkg::host_inputs_t host;
	aznable_pkg::video_sync_t  sync;
	logic                      pause;
	logic                      menu;
	aznable_pkg::layer_pixel_t charmap;
	aznable_pkg::layer_pixel_t sprite;
	aznable_pkg::layer_pixel_t tilemap;
	aznable_pkg::star_pixel_t  stars [3];
	logic                      pause_system;
	aznable_pkg::rgb_t         pixel;

	bus_step_t   steps [$];
	int unsigned total_wait;
	int          passed;
	int          failed;
	logic        table_ready = 1'b0;

	system_io i_system_io (.*);

	always #50 clk_24 = ~clk_24;

	// Sync levels on top, fixed 1 and 0, menu request, then 0
	function automatic aznable_pkg::byte_t status_byte(input logic menu_set);
		return {sync.hs, sync.vs, sync.hblank, sync.vblank, 1'b1, 1'b0, menu_set, 1'b0};
	endfunction

	function automatic aznable_pkg::layer_pixel_t random_layer(input logic active);
		logic [31:0] word;
		word = $urandom;
		return {active, word[7:0], word[15:8], word[23:16]};
	endfunction

	// Char map, sprites, tile map, star 1 full, star 2 seven bits, star 3 six bits
	function automatic aznable_pkg::rgb_t expected_pixel();
		aznable_pkg::colour_t grey;
		if (charmap.active)
			return {charmap.r, charmap.g, charmap.b};
		if (sprite.active)
			return {sprite.r, sprite.g, sprite.b};
		if (tilemap.active)
			return {tilemap.r, tilemap.g, tilemap.b};
		grey = stars[0].on ? stars[0].brightness :
			stars[1].on ? (stars[1].brightness & 8'h7F) :
			stars[2].on ? (stars[2].brightness & 8'h3F) : 8'h00;
		return {grey, grey, grey};
	endfunction

	task automatic add_step(input aznable_pkg::addr_t addr, input logic wr, input logic host_pause,
		input logic host_menu, input int unsigned wait_cycles, input logic check_din,
		input aznable_pkg::byte_t exp_din, input logic exp_pause);
		steps.push_back('{addr, wr, 8'hA5, host_pause, host_menu, wait_cycles, check_din,
			exp_din, exp_pause});
		total_wait += wait_cycles;
	endtask

	task automatic report_step(input logic ok, input string what);
		if (ok)
		begin
			passed++;
			$display("PASS %s", what);
		end
		else
		begin
			failed++;
			$display("FAIL %s", what);
		end
	endtask

	initial
	begin
		logic [639:0]      noise;
		bus_step_t         s;
		aznable_pkg::rgb_t exp_pixel;
		logic              ok;
		logic [5:0]        mix_flags [8];

		void'($urandom(72597));
		for (int i = 0; i < 20; i++)
			noise[i * 32 +: 32] = $urandom;
		host = noise[619:0];
		sync = noise[639:636];
		arst_n = 1'b0;
		bus = '{addr: 16'h0000, data: 8'h00, wr_n: 1'b1};
		pause = 1'b0;
		menu = 1'b0;
		charmap = '0;
		sprite = '0;
		tilemap = '0;
		for (int k = 0; k < 3; k++)
			stars[k] = '0;
		passed = 0;
		failed = 0;
		total_wait = 0;

		// Input reads pick byte N of the selected input
		add_step(16'h8105, 1'b0, 1'b0, 1'b0, 0, 1'b1, host.joystick[47:40], 1'b0);
		add_step(16'h8402, 1'b0, 1'b0, 1'b0, 0, 1'b1, host.paddle[23:16], 1'b0);
		add_step(16'h8801, 1'b0, 1'b0, 1'b0, 0, 1'b1, host.timestamp[15:8], 1'b0);
		add_step(16'h8601, 1'b0, 1'b0, 1'b0, 0, 1'b1, {5'd0, host.ps2_key[10:8]}, 1'b0);
		add_step(16'h8000, 1'b0, 1'b0, 1'b0, 0, 1'b1, status_byte(1'b0), 1'b0);
		add_step(16'h0000, 1'b0, 1'b0, 1'b0, 0, 1'b1, 8'h00, 1'b0);
		add_step(16'hC000, 1'b0, 1'b0, 1'b0, 0, 1'b1, 8'h00, 1'b0);
		add_step(16'h8A00, 1'b0, 1'b0, 1'b0, 0, 1'b1, 8'h00, 1'b0);
		// Host pause overrides the pause latch and then releases it
		add_step(16'h8A30, 1'b1, 1'b0, 1'b0, 0, 1'b0, 8'h00, 1'b0);
		add_step(16'h0000, 1'b0, 1'b0, 1'b0, 0, 1'b1, 8'h00, 1'b1);
		add_step(16'h0000, 1'b0, 1'b1, 1'b0, 0, 1'b1, 8'h00, 1'b1);
		add_step(16'h0000, 1'b0, 1'b1, 1'b0, 0, 1'b1, 8'h00, 1'b1);
		add_step(16'h0000, 1'b0, 1'b0, 1'b0, 0, 1'b1, 8'h00, 1'b0);
		add_step(16'h8A30, 1'b1, 1'b1, 1'b0, 0, 1'b0, 8'h00, 1'b1);
		add_step(16'h0000, 1'b0, 1'b0, 1'b0, 0, 1'b1, 8'h00, 1'b0);
		// A CPU menu write wins over a host pulse
		add_step(16'h8A31, 1'b0, 1'b0, 1'b1, 0, 1'b1, 8'h00, 1'b0);
		add_step(16'h8A31, 1'b0, 1'b0, 1'b0, 0, 1'b1, 8'hFF, 1'b0);
		add_step(16'h8000, 1'b0, 1'b0, 1'b0, 0, 1'b1, status_byte(1'b1), 1'b0);
		add_step(16'h8A31, 1'b1, 1'b0, 1'b1, 0, 1'b0, 8'h00, 1'b0);
		add_step(16'h8A31, 1'b0, 1'b0, 1'b0, 0, 1'b1, 8'h00, 1'b0);
		// Let the timer run one millisecond so that the clear has something to remove
		add_step(16'h8900, 1'b0, 1'b0, 1'b0, aznable_pkg::TICKS_PER_MS, 1'b1, 8'h00, 1'b0);
		// Timer cleared, then two milliseconds of idle bus
		add_step(16'h8900, 1'b1, 1'b0, 1'b0, 2 * aznable_pkg::TICKS_PER_MS + 10, 1'b0, 8'h00, 1'b0);
		add_step(16'h8900, 1'b0, 1'b0, 1'b0, 0, 1'b1, 8'h02, 1'b0);
		// Char, sprite, tile, star 1, star 2, star 3
		mix_flags = '{6'b100000, 6'b111111, 6'b011111, 6'b001111,
			6'b000111, 6'b000011, 6'b000001, 6'b000000};
		table_ready = 1'b1;

		repeat (2) @(posedge clk_24);
		arst_n <= 1'b1;

		foreach (steps[i])
		begin
			s = steps[i];
			@(posedge clk_24);
			bus <= '{addr: s.addr, data: s.data, wr_n: !s.wr};
			pause <= s.pause;
			menu <= s.menu;
			@(negedge clk_24);
			ok = 1'b1;
			if (s.check_din)
			begin
				assert (cpu_din == s.exp_din)
				else
				begin
					$display("Error: time %0t, cpu_din is %h, expected %h", $time, cpu_din,
						s.exp_din);
					ok = 1'b0;
				end
			end
			assert (pause_system == s.exp_pause)
			else
			begin
				$display("Error: time %0t, pause_system is %b, expected %b", $time, pause_system,
					s.exp_pause);
				ok = 1'b0;
			end
			report_step(ok, $sformatf("bus step %0d at address %h", i, s.addr));
			repeat (s.wait_cycles)
			begin
				@(posedge clk_24);
				bus <= '{addr: 16'h0000, data: 8'h00, wr_n: 1'b1};
				pause <= 1'b0;
				menu <= 1'b0;
			end
		end

		foreach (mix_flags[i])
		begin
			@(posedge clk_24);
			charmap <= random_layer(mix_flags[i][5]);
			sprite <= random_layer(mix_flags[i][4]);
			tilemap <= random_layer(mix_flags[i][3]);
			// Top brightness bits set so the star masks show
			for (int k = 0; k < 3; k++)
				stars[k] <= '{on: mix_flags[i][2 - k], brightness: 8'hC0 | 8'($urandom)};
			@(negedge clk_24);
			exp_pixel = expected_pixel();
			ok = 1'b1;
			assert (pixel == exp_pixel)
			else
			begin
				$display("Error: time %0t, pixel is %h, expected %h", $time, pixel, exp_pixel);
				ok = 1'b0;
			end
			report_step(ok, $sformatf("mixer with layer flags %b", mix_flags[i]));
		end

		$display("%0d tests passed, %0d failed", passed, failed);
		if (failed == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	// Watchdog sized from the waits in the table
	initial
	begin
		wait (table_ready);
		repeat (total_wait + 200) @(posedge clk_24);
		$display("Timeout: the test table did not finish within %0d cycles", total_wait + 200);
		$display("Finished with errors");
		$finish;
	end

endmodule

// ==== vlog.f ====
source/aznable_pkg.sv
source/address_decoder.sv
source/input_port_mux.sv
source/system_control.sv
source/layer_mixer.sv
source/system_io.sv
sim/tb_system_io.sv

// ==== Makefile ====
# Verilator lint, simulation and cleanup for the system I/O block

TOP = tb_system_io

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f vlog.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f vlog.f \
		--Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "^Finished with no errors$$" sim.log

clean:
	rm -rf obj_dir sim.log
